// File: hdl/ctrl_defines.svh
`ifndef CTRL_DEFINES_SVH
`define CTRL_DEFINES_SVH

// Instruction and register file geometry
`define INSTR_W 32
`define REG_IDX_W 5

// Fixed register numbers
`define REG_ZERO 5'd0
`define REG_RA 5'd31 // Link register for jal

// Use/produce cycle counts
`define TICK_W 3
`define TICK_INF 3'd7 // Operand never read

`endif

// File: hdl/ctrl_pkg.sv
`default_nettype none

`include "ctrl_defines.svh"

package ctrl_pkg;

	typedef logic [`INSTR_W-1:0] instr_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;
	typedef logic [`TICK_W-1:0] tick_t;

	typedef enum logic [5:0] {
		KIND_NOP,
		KIND_ADDU, KIND_SUBU, KIND_ADD, KIND_SUB,
		KIND_AND, KIND_OR, KIND_NOR, KIND_XOR,
		KIND_SLT, KIND_SLTU,
		KIND_SLL, KIND_SRL, KIND_SRA, KIND_SLLV, KIND_SRLV, KIND_SRAV,
		KIND_LUI, KIND_ORI, KIND_ADDI, KIND_ADDIU,
		KIND_ANDI, KIND_XORI, KIND_SLTI, KIND_SLTIU,
		KIND_LW, KIND_LH, KIND_LHU, KIND_LB, KIND_LBU,
		KIND_SW, KIND_SH, KIND_SB,
		KIND_BEQ, KIND_BNE, KIND_BLEZ, KIND_BGTZ, KIND_BLTZ, KIND_BGEZ,
		KIND_J, KIND_JAL, KIND_JR, KIND_JALR
	} instr_kind_e;

	typedef enum logic [2:0] {
		CLS_NONE, CLS_CAL_R, CLS_CAL_I, CLS_LOAD,
		CLS_STORE, CLS_BRANCH, CLS_JUMP_I, CLS_JUMP_R
	} instr_class_e;

	// One mode per branch condition, then the jumps
	typedef enum logic [3:0] {
		NPC_DISABLED, NPC_EQUAL, NPC_NOT_EQUAL, NPC_LE_ZERO,
		NPC_GT_ZERO, NPC_LT_ZERO, NPC_GE_ZERO, NPC_J, NPC_REG
	} npc_mode_e;

	typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_PAD} ext_mode_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
		ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLLV, ALU_SRLV, ALU_SRAV
	} alu_op_e;

	typedef enum logic [2:0] {
		MEM_NONE, MEM_W, MEM_H, MEM_HU, MEM_B, MEM_BU
	} mem_mode_e;

	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_NPC} wb_src_e;

	typedef enum logic [2:0] {
		FWD_ORIG, FWD_E_NPC, FWD_M_NPC, FWD_M_ALU, FWD_W_RF
	} fwd_src_e;

endpackage

`default_nettype wire

// File: hdl/instr_decoder.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defines.svh"

module instr_decoder import ctrl_pkg::*; (
	input  instr_t       instr,
	output instr_kind_e  kind,
	output instr_class_e cls,
	output reg_idx_t     src1,
	output reg_idx_t     src2,
	output reg_idx_t     dst
);

	logic [5:0] op;
	logic [5:0] funct;
	reg_idx_t   rs, rt, rd;
	logic       rs_z, rt_z, rd_z, sh_z;

	assign op    = instr[31:26];
	assign funct = instr[5:0];
	assign rs    = instr[25:21];
	assign rt    = instr[20:16];
	assign rd    = instr[15:11];
	assign rs_z  = (rs == `REG_ZERO);
	assign rt_z  = (rt == `REG_ZERO);
	assign rd_z  = (rd == `REG_ZERO);
	assign sh_z  = (instr[10:6] == 5'd0);

	always_comb begin
		kind = KIND_NOP;
		if (instr != '0) begin // All-zero word is the bubble
			case (op)
				6'b000000: begin
					case (funct)
						6'b100001: kind = sh_z ? KIND_ADDU : KIND_NOP;
						6'b100011: kind = sh_z ? KIND_SUBU : KIND_NOP;
						6'b100000: kind = sh_z ? KIND_ADD : KIND_NOP;
						6'b100010: kind = sh_z ? KIND_SUB : KIND_NOP;
						6'b100100: kind = sh_z ? KIND_AND : KIND_NOP;
						6'b100101: kind = sh_z ? KIND_OR : KIND_NOP;
						6'b100111: kind = sh_z ? KIND_NOR : KIND_NOP;
						6'b100110: kind = sh_z ? KIND_XOR : KIND_NOP;
						6'b101010: kind = sh_z ? KIND_SLT : KIND_NOP;
						6'b101011: kind = sh_z ? KIND_SLTU : KIND_NOP;
						6'b000000: kind = rs_z ? KIND_SLL : KIND_NOP;
						6'b000010: kind = rs_z ? KIND_SRL : KIND_NOP;
						6'b000011: kind = rs_z ? KIND_SRA : KIND_NOP;
						6'b000100: kind = sh_z ? KIND_SLLV : KIND_NOP;
						6'b000110: kind = sh_z ? KIND_SRLV : KIND_NOP;
						6'b000111: kind = sh_z ? KIND_SRAV : KIND_NOP;
						6'b001000: kind = (rt_z && rd_z) ? KIND_JR : KIND_NOP;
						6'b001001: kind = rt_z ? KIND_JALR : KIND_NOP;
						default:   kind = KIND_NOP;
					endcase
				end
				6'b001111: kind = rs_z ? KIND_LUI : KIND_NOP;
				6'b001101: kind = KIND_ORI;
				6'b001000: kind = KIND_ADDI;
				6'b001001: kind = KIND_ADDIU;
				6'b001100: kind = KIND_ANDI;
				6'b001110: kind = KIND_XORI;
				6'b001010: kind = KIND_SLTI;
				6'b001011: kind = KIND_SLTIU;
				6'b100011: kind = KIND_LW;
				6'b100001: kind = KIND_LH;
				6'b100101: kind = KIND_LHU;
				6'b100000: kind = KIND_LB;
				6'b100100: kind = KIND_LBU;
				6'b101011: kind = KIND_SW;
				6'b101001: kind = KIND_SH;
				6'b101000: kind = KIND_SB;
				6'b000100: kind = KIND_BEQ;
				6'b000101: kind = KIND_BNE;
				6'b000110: kind = rt_z ? KIND_BLEZ : KIND_NOP;
				6'b000111: kind = rt_z ? KIND_BGTZ : KIND_NOP;
				// REGIMM, condition sits in rt
				6'b000001: begin
					if (rt == 5'd0)
						kind = KIND_BLTZ;
					else if (rt == 5'd1)
						kind = KIND_BGEZ;
				end
				6'b000010: kind = KIND_J;
				6'b000011: kind = KIND_JAL;
				default:   kind = KIND_NOP;
			endcase
		end
	end

	always_comb begin
		case (kind)
			KIND_ADDU, KIND_SUBU, KIND_ADD, KIND_SUB, KIND_AND, KIND_OR,
			KIND_NOR, KIND_XOR, KIND_SLT, KIND_SLTU, KIND_SLL, KIND_SRL,
			KIND_SRA, KIND_SLLV, KIND_SRLV, KIND_SRAV: cls = CLS_CAL_R;
			KIND_LUI, KIND_ORI, KIND_ADDI, KIND_ADDIU, KIND_ANDI,
			KIND_XORI, KIND_SLTI, KIND_SLTIU:          cls = CLS_CAL_I;
			KIND_LW, KIND_LH, KIND_LHU, KIND_LB, KIND_LBU: cls = CLS_LOAD;
			KIND_SW, KIND_SH, KIND_SB:                 cls = CLS_STORE;
			KIND_BEQ, KIND_BNE, KIND_BLEZ, KIND_BGTZ,
			KIND_BLTZ, KIND_BGEZ:                      cls = CLS_BRANCH;
			KIND_J, KIND_JAL:                          cls = CLS_JUMP_I;
			KIND_JR, KIND_JALR:                        cls = CLS_JUMP_R;
			default:                                   cls = CLS_NONE;
		endcase
	end

	assign src1 = (cls inside {CLS_CAL_R, CLS_CAL_I, CLS_LOAD, CLS_STORE,
		CLS_BRANCH, CLS_JUMP_R}) ? rs : `REG_ZERO;

	assign src2 = (cls inside {CLS_CAL_R, CLS_STORE} || kind inside {KIND_BEQ, KIND_BNE})
		? rt : `REG_ZERO;

	always_comb begin
		if (cls == CLS_CAL_R || kind == KIND_JALR)
			dst = rd;
		else if (cls inside {CLS_CAL_I, CLS_LOAD})
			dst = rt;
		else if (kind == KIND_JAL)
			dst = `REG_RA;
		else
			dst = `REG_ZERO; // Stores, branches, j, jr
	end

endmodule

`default_nettype wire

// File: hdl/stage_tracker.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defines.svh"

module stage_tracker import ctrl_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall,
	input  instr_t   d_instr,
	input  reg_idx_t d_src1,
	input  reg_idx_t d_src2,
	input  reg_idx_t d_dst,
	output instr_t   e_instr,
	output instr_t   m_instr,
	output instr_t   w_instr,
	output reg_idx_t e_src1,
	output reg_idx_t e_src2,
	output reg_idx_t e_dst,
	output reg_idx_t m_src2,
	output reg_idx_t m_dst,
	output reg_idx_t w_dst
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_instr <= '0;
			m_instr <= '0;
			w_instr <= '0;
			e_src1  <= `REG_ZERO;
			e_src2  <= `REG_ZERO;
			e_dst   <= `REG_ZERO;
			m_src2  <= `REG_ZERO;
			m_dst   <= `REG_ZERO;
			w_dst   <= `REG_ZERO;
		end else begin
			// Bubble into execute while decode is held
			e_instr <= stall ? '0 : d_instr;
			e_src1  <= stall ? `REG_ZERO : d_src1;
			e_src2  <= stall ? `REG_ZERO : d_src2;
			e_dst   <= stall ? `REG_ZERO : d_dst;

			m_instr <= e_instr; // Later stages never hold
			m_src2  <= e_src2;
			m_dst   <= e_dst;
			w_instr <= m_instr;
			w_dst   <= m_dst;
		end
	end

	// A stalled instruction must not leave a stale producer in execute
	a_bubble_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> (e_dst == `REG_ZERO));

endmodule

`default_nettype wire

// File: hdl/hazard_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defines.svh"

module hazard_unit import ctrl_pkg::*; (
	input  instr_class_e d_cls,
	input  instr_class_e e_cls,
	input  instr_class_e m_cls,
	input  instr_class_e w_cls,
	input  reg_idx_t     d_src1,
	input  reg_idx_t     d_src2,
	input  reg_idx_t     e_src1,
	input  reg_idx_t     e_src2,
	input  reg_idx_t     e_dst,
	input  reg_idx_t     m_src2,
	input  reg_idx_t     m_dst,
	input  reg_idx_t     w_dst,
	output logic         stall,
	output fwd_src_e     d_fwd1,
	output fwd_src_e     d_fwd2,
	output fwd_src_e     e_fwd1,
	output fwd_src_e     e_fwd2,
	output fwd_src_e     m_fwd2
);

	tick_t tuse1, tuse2, tnew_e, tnew_m;
	logic  e_link, m_link, m_alu, w_wr;

	function automatic logic hit(input reg_idx_t src, input reg_idx_t dst);
		return (src == dst) && (src != `REG_ZERO);
	endfunction

	function automatic fwd_src_e fwd_from_m(input reg_idx_t src);
		if (hit(src, m_dst) && m_link)
			return FWD_M_NPC;
		if (hit(src, m_dst) && m_alu)
			return FWD_M_ALU;
		if (hit(src, w_dst) && w_wr)
			return FWD_W_RF;
		return FWD_ORIG;
	endfunction

	always_comb begin
		case (d_cls)
			CLS_BRANCH, CLS_JUMP_R:                    tuse1 = tick_t'(0);
			CLS_CAL_R, CLS_CAL_I, CLS_LOAD, CLS_STORE: tuse1 = tick_t'(1);
			default:                                   tuse1 = `TICK_INF;
		endcase
		case (d_cls)
			CLS_STORE:  tuse2 = tick_t'(2); // Data needed only in memory
			CLS_CAL_R:  tuse2 = tick_t'(1);
			CLS_BRANCH: tuse2 = tick_t'(0); // Only beq/bne carry a second source
			default:    tuse2 = `TICK_INF;
		endcase
	end

	assign tnew_e = (e_cls == CLS_LOAD) ? tick_t'(2) :
		(e_cls inside {CLS_CAL_R, CLS_CAL_I}) ? tick_t'(1) : tick_t'(0);
	assign tnew_m = (m_cls == CLS_LOAD) ? tick_t'(1) : tick_t'(0);

	assign e_link = e_cls inside {CLS_JUMP_I, CLS_JUMP_R};
	assign m_link = m_cls inside {CLS_JUMP_I, CLS_JUMP_R};
	assign m_alu  = m_cls inside {CLS_CAL_R, CLS_CAL_I};
	assign w_wr   = w_cls inside {CLS_CAL_R, CLS_CAL_I, CLS_LOAD, CLS_JUMP_I, CLS_JUMP_R};

	assign stall = (hit(d_src1, e_dst) && (tuse1 < tnew_e))
		|| (hit(d_src1, m_dst) && (tuse1 < tnew_m))
		|| (hit(d_src2, e_dst) && (tuse2 < tnew_e))
		|| (hit(d_src2, m_dst) && (tuse2 < tnew_m));

	always_comb begin
		d_fwd1 = (hit(d_src1, e_dst) && e_link) ? FWD_E_NPC : fwd_from_m(d_src1);
		d_fwd2 = (hit(d_src2, e_dst) && e_link) ? FWD_E_NPC : fwd_from_m(d_src2);
		e_fwd1 = fwd_from_m(e_src1);
		e_fwd2 = fwd_from_m(e_src2);
		m_fwd2 = (hit(m_src2, w_dst) && w_wr) ? FWD_W_RF : FWD_ORIG;

		// r0 always reads as zero from the register file
		assert ((d_src1 != `REG_ZERO || d_fwd1 == FWD_ORIG)
			&& (d_src2 != `REG_ZERO || d_fwd2 == FWD_ORIG)
			&& (e_src1 != `REG_ZERO || e_fwd1 == FWD_ORIG)
			&& (e_src2 != `REG_ZERO || e_fwd2 == FWD_ORIG)
			&& (m_src2 != `REG_ZERO || m_fwd2 == FWD_ORIG))
			else $error("forward select on a zero source");
	end

endmodule

`default_nettype wire

// File: hdl/ctrl_word_gen.sv
`default_nettype none
`timescale 1ns/100ps

`include "ctrl_defines.svh"

module ctrl_word_gen import ctrl_pkg::*; (
	input  instr_kind_e  d_kind,
	input  instr_kind_e  e_kind,
	input  instr_kind_e  m_kind,
	input  instr_kind_e  w_kind,
	input  instr_class_e d_cls,
	input  instr_class_e e_cls,
	input  instr_class_e m_cls,
	input  instr_class_e w_cls,
	input  reg_idx_t     w_dst,
	output npc_mode_e    d_npc_mode,
	output ext_mode_e    d_ext_mode,
	output alu_op_e      e_alu_op,
	output logic         e_alu_imm,
	output logic         m_dm_write_enable,
	output mem_mode_e    m_dm_mode,
	output logic         w_rf_write_enable,
	output wb_src_e      w_wb_src,
	output reg_idx_t     w_rf_write_addr
);

	always_comb begin
		d_npc_mode = NPC_DISABLED;
		if (d_cls == CLS_JUMP_I)
			d_npc_mode = NPC_J;
		else if (d_cls == CLS_JUMP_R)
			d_npc_mode = NPC_REG;
		else if (d_cls == CLS_BRANCH) begin
			case (d_kind)
				KIND_BEQ:  d_npc_mode = NPC_EQUAL;
				KIND_BNE:  d_npc_mode = NPC_NOT_EQUAL;
				KIND_BLEZ: d_npc_mode = NPC_LE_ZERO;
				KIND_BGTZ: d_npc_mode = NPC_GT_ZERO;
				KIND_BLTZ: d_npc_mode = NPC_LT_ZERO;
				KIND_BGEZ: d_npc_mode = NPC_GE_ZERO;
				default:   d_npc_mode = NPC_DISABLED;
			endcase
		end
	end

	assign d_ext_mode = (d_kind == KIND_LUI) ? EXT_PAD :
		(d_kind inside {KIND_ORI, KIND_ANDI, KIND_XORI}) ? EXT_ZERO : EXT_SIGN;

	always_comb begin
		case (e_kind)
			KIND_ADDU, KIND_ADD, KIND_ADDI, KIND_ADDIU,
			KIND_LW, KIND_LH, KIND_LHU, KIND_LB, KIND_LBU,
			KIND_SW, KIND_SH, KIND_SB: e_alu_op = ALU_ADD; // Address calc
			KIND_SUBU, KIND_SUB:       e_alu_op = ALU_SUB;
			KIND_AND, KIND_ANDI:       e_alu_op = ALU_AND;
			KIND_NOR:                  e_alu_op = ALU_NOR;
			KIND_XOR, KIND_XORI:       e_alu_op = ALU_XOR;
			KIND_SLT, KIND_SLTI:       e_alu_op = ALU_SLT;
			KIND_SLTU, KIND_SLTIU:     e_alu_op = ALU_SLTU;
			KIND_SLL:                  e_alu_op = ALU_SLL;
			KIND_SRL:                  e_alu_op = ALU_SRL;
			KIND_SRA:                  e_alu_op = ALU_SRA;
			KIND_SLLV:                 e_alu_op = ALU_SLLV;
			KIND_SRLV:                 e_alu_op = ALU_SRLV;
			KIND_SRAV:                 e_alu_op = ALU_SRAV;
			default:                   e_alu_op = ALU_OR; // or, ori, lui pass-through
		endcase
	end

	assign e_alu_imm = e_cls inside {CLS_CAL_I, CLS_LOAD, CLS_STORE};

	always_comb begin
		case (m_kind)
			KIND_LW, KIND_SW: m_dm_mode = MEM_W;
			KIND_LH, KIND_SH: m_dm_mode = MEM_H;
			KIND_LHU:         m_dm_mode = MEM_HU;
			KIND_LB, KIND_SB: m_dm_mode = MEM_B;
			KIND_LBU:         m_dm_mode = MEM_BU;
			default:          m_dm_mode = MEM_NONE;
		endcase
		m_dm_write_enable = (m_cls == CLS_STORE);

		assert (!m_dm_write_enable || m_dm_mode != MEM_NONE)
			else $error("store without access width");
	end

	assign w_rf_write_enable = (w_cls inside {CLS_CAL_R, CLS_CAL_I, CLS_LOAD}
		|| w_kind inside {KIND_JAL, KIND_JALR}) && (w_dst != `REG_ZERO);
	assign w_wb_src = (w_cls == CLS_LOAD) ? WB_MEM :
		(w_kind inside {KIND_JAL, KIND_JALR}) ? WB_NPC : WB_ALU;
	assign w_rf_write_addr = w_dst;

endmodule

`default_nettype wire

// File: hdl/pipeline_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module pipeline_ctrl import ctrl_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  instr_t    d_instr,
	output logic      pc_enable,
	output logic      stall,
	output npc_mode_e d_npc_mode,
	output ext_mode_e d_ext_mode,
	output alu_op_e   e_alu_op,
	output logic      e_alu_imm,
	output logic      m_dm_write_enable,
	output mem_mode_e m_dm_mode,
	output logic      w_rf_write_enable,
	output wb_src_e   w_wb_src,
	output reg_idx_t  w_rf_write_addr,
	output fwd_src_e  d_fwd1,
	output fwd_src_e  d_fwd2,
	output fwd_src_e  e_fwd1,
	output fwd_src_e  e_fwd2,
	output fwd_src_e  m_fwd2
);

	instr_t       e_instr, m_instr, w_instr;
	instr_kind_e  d_kind, e_kind, m_kind, w_kind;
	instr_class_e d_cls, e_cls, m_cls, w_cls;
	reg_idx_t     d_src1, d_src2, d_dst;
	reg_idx_t     e_src1, e_src2, e_dst, m_src2, m_dst, w_dst;

	// Register roles only matter in decode, later stages carry them
	instr_decoder u_dec_d (.instr(d_instr), .kind(d_kind), .cls(d_cls),
		.src1(d_src1), .src2(d_src2), .dst(d_dst));
	instr_decoder u_dec_e (.instr(e_instr), .kind(e_kind), .cls(e_cls),
		.src1(), .src2(), .dst());
	instr_decoder u_dec_m (.instr(m_instr), .kind(m_kind), .cls(m_cls),
		.src1(), .src2(), .dst());
	instr_decoder u_dec_w (.instr(w_instr), .kind(w_kind), .cls(w_cls),
		.src1(), .src2(), .dst());

	stage_tracker u_stage_tracker (
		.clk(clk), .rst_n(rst_n), .stall(stall),
		.d_instr(d_instr), .d_src1(d_src1), .d_src2(d_src2), .d_dst(d_dst),
		.e_instr(e_instr), .m_instr(m_instr), .w_instr(w_instr),
		.e_src1(e_src1), .e_src2(e_src2), .e_dst(e_dst),
		.m_src2(m_src2), .m_dst(m_dst), .w_dst(w_dst)
	);

	hazard_unit u_hazard_unit (
		.d_cls(d_cls), .e_cls(e_cls), .m_cls(m_cls), .w_cls(w_cls),
		.d_src1(d_src1), .d_src2(d_src2), .e_src1(e_src1), .e_src2(e_src2),
		.e_dst(e_dst), .m_src2(m_src2), .m_dst(m_dst), .w_dst(w_dst),
		.stall(stall), .d_fwd1(d_fwd1), .d_fwd2(d_fwd2),
		.e_fwd1(e_fwd1), .e_fwd2(e_fwd2), .m_fwd2(m_fwd2)
	);

	ctrl_word_gen u_ctrl_word_gen (
		.d_kind(d_kind), .e_kind(e_kind), .m_kind(m_kind), .w_kind(w_kind),
		.d_cls(d_cls), .e_cls(e_cls), .m_cls(m_cls), .w_cls(w_cls), .w_dst(w_dst),
		.d_npc_mode(d_npc_mode), .d_ext_mode(d_ext_mode),
		.e_alu_op(e_alu_op), .e_alu_imm(e_alu_imm),
		.m_dm_write_enable(m_dm_write_enable), .m_dm_mode(m_dm_mode),
		.w_rf_write_enable(w_rf_write_enable), .w_wb_src(w_wb_src),
		.w_rf_write_addr(w_rf_write_addr)
	);

	assign pc_enable = ~stall; // Fetch and decode hold together

endmodule

`default_nettype wire

// File: dv/pipeline_ctrl_tb.sv
`default_nettype none
`timescale 1ns/100ps

module pipeline_ctrl_tb import ctrl_pkg::*; ();

	localparam int WAIT_LIMIT = 20;

	logic      clk;
	logic      rst_n;
	instr_t    d_instr;
	logic      pc_enable, stall, e_alu_imm, m_dm_write_enable, w_rf_write_enable;
	npc_mode_e d_npc_mode;
	ext_mode_e d_ext_mode;
	alu_op_e   e_alu_op;
	mem_mode_e m_dm_mode;
	wb_src_e   w_wb_src;
	reg_idx_t  w_rf_write_addr;
	fwd_src_e  d_fwd1, d_fwd2, e_fwd1, e_fwd2, m_fwd2;

	// Expected values and their check enables, valid for one cycle
	logic c_stall, c_npc, c_ext, c_alu, c_mem, c_wb, c_d1, c_d2, c_e1, c_e2, c_m2;
	logic      x_stall, x_alu_imm, x_dm_we, x_rf_we;
	npc_mode_e x_npc;
	ext_mode_e x_ext;
	alu_op_e   x_alu;
	mem_mode_e x_dm_mode;
	wb_src_e   x_wb_src;
	reg_idx_t  x_rf_addr;
	fwd_src_e  x_d1, x_d2, x_e1, x_e2, x_m2;
	int        errors;
	int        tests;

	pipeline_ctrl u_pipeline_ctrl (
		.clk(clk), .rst_n(rst_n), .d_instr(d_instr),
		.pc_enable(pc_enable), .stall(stall),
		.d_npc_mode(d_npc_mode), .d_ext_mode(d_ext_mode),
		.e_alu_op(e_alu_op), .e_alu_imm(e_alu_imm),
		.m_dm_write_enable(m_dm_write_enable), .m_dm_mode(m_dm_mode),
		.w_rf_write_enable(w_rf_write_enable), .w_wb_src(w_wb_src),
		.w_rf_write_addr(w_rf_write_addr),
		.d_fwd1(d_fwd1), .d_fwd2(d_fwd2), .e_fwd1(e_fwd1), .e_fwd2(e_fwd2), .m_fwd2(m_fwd2)
	);

	always #5 clk = ~clk;

	task automatic report(input string name, input int exp, input int got);
		errors++;
		$display("ERR t=%0t %s expected %0d observed %0d", $time, name, exp, got);
	endtask

	a_stall: assert property (@(negedge clk) c_stall |-> (stall == x_stall))
		else report("stall", x_stall, stall);
	a_pc_en: assert property (@(negedge clk) c_stall |-> (pc_enable == !x_stall))
		else report("pc_enable", !x_stall, pc_enable);
	a_npc: assert property (@(negedge clk) c_npc |-> (d_npc_mode == x_npc))
		else report("d_npc_mode", x_npc, d_npc_mode);
	a_ext: assert property (@(negedge clk) c_ext |-> (d_ext_mode == x_ext))
		else report("d_ext_mode", x_ext, d_ext_mode);
	a_alu: assert property (@(negedge clk) c_alu |-> (e_alu_op == x_alu))
		else report("e_alu_op", x_alu, e_alu_op);
	a_imm: assert property (@(negedge clk) c_alu |-> (e_alu_imm == x_alu_imm))
		else report("e_alu_imm", x_alu_imm, e_alu_imm);
	a_dm_we: assert property (@(negedge clk) c_mem |-> (m_dm_write_enable == x_dm_we))
		else report("m_dm_write_enable", x_dm_we, m_dm_write_enable);
	a_dm_mode: assert property (@(negedge clk) (c_mem && x_dm_we) |-> (m_dm_mode == x_dm_mode))
		else report("m_dm_mode", x_dm_mode, m_dm_mode);
	a_rf_we: assert property (@(negedge clk) c_wb |-> (w_rf_write_enable == x_rf_we))
		else report("w_rf_write_enable", x_rf_we, w_rf_write_enable);
	a_wb_src: assert property (@(negedge clk) (c_wb && x_rf_we) |-> (w_wb_src == x_wb_src))
		else report("w_wb_src", x_wb_src, w_wb_src);
	a_rf_addr: assert property (@(negedge clk) (c_wb && x_rf_we) |-> (w_rf_write_addr == x_rf_addr))
		else report("w_rf_write_addr", x_rf_addr, w_rf_write_addr);
	a_d1: assert property (@(negedge clk) c_d1 |-> (d_fwd1 == x_d1))
		else report("d_fwd1", x_d1, d_fwd1);
	a_d2: assert property (@(negedge clk) c_d2 |-> (d_fwd2 == x_d2))
		else report("d_fwd2", x_d2, d_fwd2);
	a_e1: assert property (@(negedge clk) c_e1 |-> (e_fwd1 == x_e1))
		else report("e_fwd1", x_e1, e_fwd1);
	a_e2: assert property (@(negedge clk) c_e2 |-> (e_fwd2 == x_e2))
		else report("e_fwd2", x_e2, e_fwd2);
	a_m2: assert property (@(negedge clk) c_m2 |-> (m_fwd2 == x_m2))
		else report("m_fwd2", x_m2, m_fwd2);

	// MIPS encodings
	function automatic instr_t rtype(input logic [5:0] funct, input reg_idx_t rs,
		input reg_idx_t rt, input reg_idx_t rd);
		return {6'b000000, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic instr_t itype(input logic [5:0] op, input reg_idx_t rs,
		input reg_idx_t rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic instr_t jtype(input logic [5:0] op);
		return {op, 26'h0000040};
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
		{c_stall, c_npc, c_ext, c_alu, c_mem, c_wb} = '0;
		{c_d1, c_d2, c_e1, c_e2, c_m2} = '0;
	endtask

	// Holds decode until the stall clears, then presents the next word
	task automatic issue(input instr_t w);
		int n;
		n = 0;
		@(negedge clk); // Stall has settled mid-cycle
		while (!pc_enable && n < WAIT_LIMIT) begin
			step();
			@(negedge clk);
			n++;
		end
		if (!pc_enable) begin
			errors++;
			$display("timeout: stall did not release within %0d cycles", WAIT_LIMIT);
		end
		step();
		d_instr = w;
	endtask

	task automatic drain(input int n);
		repeat (n) issue('0);
	endtask

	task automatic expect_stall(input logic v);
		c_stall = 1'b1;
		x_stall = v;
	endtask

	task automatic expect_alu(input alu_op_e op, input logic imm);
		c_alu = 1'b1;
		x_alu = op;
		x_alu_imm = imm;
	endtask

	task automatic expect_wb(input logic we, input wb_src_e src, input reg_idx_t addr);
		c_wb = 1'b1;
		x_rf_we = we;
		x_wb_src = src;
		x_rf_addr = addr;
	endtask

	task automatic expect_idle();
		expect_stall(1'b0);
		{c_npc, c_mem, c_d1, c_d2, c_e1, c_e2, c_m2} = '1;
		x_npc = NPC_DISABLED;
		x_dm_we = 1'b0;
		x_d1 = FWD_ORIG;
		x_d2 = FWD_ORIG;
		x_e1 = FWD_ORIG;
		x_e2 = FWD_ORIG;
		x_m2 = FWD_ORIG;
		expect_wb(1'b0, WB_ALU, 5'd0);
	endtask

	task automatic finish_test(input string name, input int err_before);
		tests++;
		$display("test %-12s done, %0d errors", name, errors - err_before);
	endtask

	initial begin
		int e0;
		clk = 1'b0;
		rst_n = 1'b0;
		d_instr = '0;
		errors = 0;
		tests = 0;
		{c_stall, c_npc, c_ext, c_alu, c_mem, c_wb} = '0;
		{c_d1, c_d2, c_e1, c_e2, c_m2} = '0;

		e0 = errors;
		repeat (5) begin
			step();
			expect_idle();
		end
		rst_n = 1'b1;
		step();
		expect_idle();
		finish_test("reset", e0);

		e0 = errors;
		issue(itype(6'b001001, 5'd1, 5'd5, 16'h0004)); // addiu r5
		c_ext = 1'b1;
		x_ext = EXT_SIGN;
		issue('0);
		expect_alu(ALU_ADD, 1'b1);
		drain(2);
		expect_wb(1'b1, WB_ALU, 5'd5);
		issue(itype(6'b101001, 5'd2, 5'd6, 16'h0010)); // sh
		drain(2);
		c_mem = 1'b1;
		x_dm_we = 1'b1;
		x_dm_mode = MEM_H;
		issue(itype(6'b100100, 5'd2, 5'd7, 16'h0003)); // lbu r7
		drain(3);
		expect_wb(1'b1, WB_MEM, 5'd7);
		drain(1);
		finish_test("ctrl_timing", e0);

		e0 = errors;
		issue(rtype(6'b100001, 5'd1, 5'd2, 5'd3)); // addu r3
		issue(rtype(6'b100011, 5'd3, 5'd1, 5'd4)); // subu reads r3
		expect_stall(1'b0);
		issue('0);
		c_e1 = 1'b1;
		x_e1 = FWD_M_ALU;
		drain(3);
		issue(rtype(6'b100001, 5'd1, 5'd2, 5'd3));
		drain(2);
		issue(rtype(6'b100011, 5'd3, 5'd1, 5'd4));
		c_d1 = 1'b1;
		x_d1 = FWD_W_RF;
		drain(3);
		issue(jtype(6'b000011)); // jal
		c_npc = 1'b1;
		x_npc = NPC_J;
		issue(rtype(6'b100001, 5'd31, 5'd1, 5'd8)); // addu reads r31
		expect_stall(1'b0);
		c_d1 = 1'b1;
		x_d1 = FWD_E_NPC;
		drain(3);
		finish_test("forwarding", e0);

		e0 = errors;
		issue(itype(6'b100011, 5'd1, 5'd4, 16'h0000)); // lw r4
		issue(rtype(6'b100001, 5'd4, 5'd2, 5'd9)); // load-use
		expect_stall(1'b1);
		step();
		expect_stall(1'b0);
		expect_alu(ALU_OR, 1'b0); // bubble in execute
		issue('0);
		c_e1 = 1'b1;
		x_e1 = FWD_W_RF;
		expect_alu(ALU_ADD, 1'b0);
		drain(3);
		issue(itype(6'b100011, 5'd1, 5'd4, 16'h0000));
		issue(itype(6'b101011, 5'd1, 5'd4, 16'h0008)); // sw stores r4
		expect_stall(1'b0);
		drain(2);
		c_m2 = 1'b1;
		x_m2 = FWD_W_RF;
		drain(2);
		finish_test("load_use", e0);

		e0 = errors;
		issue(rtype(6'b100001, 5'd1, 5'd3, 5'd2)); // addu r2
		issue(itype(6'b000100, 5'd2, 5'd0, 16'h0002)); // beq r2, r0
		expect_stall(1'b1);
		step();
		expect_stall(1'b0);
		c_d1 = 1'b1;
		x_d1 = FWD_M_ALU;
		c_npc = 1'b1;
		x_npc = NPC_EQUAL;
		issue(jtype(6'b000010)); // j
		c_npc = 1'b1;
		x_npc = NPC_J;
		issue(rtype(6'b001000, 5'd5, 5'd0, 5'd0)); // jr r5
		c_npc = 1'b1;
		x_npc = NPC_REG;
		drain(3);
		issue(rtype(6'b100001, 5'd1, 5'd2, 5'd0)); // addu to r0
		drain(3);
		expect_wb(1'b0, WB_ALU, 5'd0);
		drain(1);
		finish_test("branch", e0);

		$display("tests %0d, errors %0d", tests, errors);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+hdl
hdl/ctrl_pkg.sv
hdl/instr_decoder.sv
hdl/stage_tracker.sv
hdl/hazard_unit.sv
hdl/ctrl_word_gen.sv
hdl/pipeline_ctrl.sv
dv/pipeline_ctrl_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = pipeline_ctrl_tb
FILELIST = src.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(wildcard hdl/*.sv hdl/*.svh dv/*.sv)

.PHONY: all run check clean

all: check

$(BIN): $(FILELIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)

check: run
	grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
